/* div_arith_pkg.sv */
// Divider arithmetic package with operand widths, iteration constants and datapath types
package div_arith_pkg;

    // Operand width
    localparam int div_width = 32;

    // Radix-4 stages chained inside one iteration
    localparam int digits_per_step = 4;

    // Each stage retires two quotient bits
    localparam int step_count = div_width / (2 * digits_per_step);

    // Plain operand or result word
    typedef logic [div_width-1:0] word_t;

    // Working word: partial remainder on top, dividend and quotient bits below
    typedef logic [2*div_width-1:0] work_t;

    // One radix-4 quotient digit
    typedef logic [1:0] digit_t;

endpackage

/* div_control.sv */
// Divider sequencer with iteration counter, ready flag and one-cycle done pulse
module div_control
    import div_arith_pkg::*;
    import div_ctl_pkg::*;
(
    input  logic ctl_clk,
    input  logic reset,
    input  logic trigger,
    output logic ready,
    output logic done,
    output logic load,
    output logic shift,
    output logic finish
);

    ctl_state_t state;
    ctl_state_t state_next;
    count_t     count;
    logic       last_step;

    // Operands are taken in idle or straight out of done, never in the cycle after reset
    assign load   = trigger && ready;
    assign shift  = (state == st_calc);
    assign finish = (state == st_done);

    assign last_step = (count == count_t'(step_count - 1));

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (load) begin
                    state_next = st_calc;
                end
            end
            st_calc: begin
                if (last_step) begin
                    state_next = st_done;
                end
            end
            st_done: begin
                state_next = load ? st_calc : st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= st_idle;
            count <= '0;
            ready <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                count <= '0;
            end else if (shift) begin
                count <= count + 1'b1;
            end
            // Ready tracks the idle and done states
            ready <= (state_next == st_idle) || (state_next == st_done);
            done  <= finish;
        end
    end

endmodule

/* div_ctl_pkg.sv */
// Divider sequencer package with state encoding and iteration counter type
package div_ctl_pkg;

    // Counter width, covers step_count of the datapath
    localparam int count_width = 3;

    // Sequencer states
    typedef enum logic [1:0] {
        st_idle = 2'h0,
        st_calc = 2'h1,
        st_done = 2'h2
    } ctl_state_t;

    // Iteration counter
    typedef logic [count_width-1:0] count_t;

endpackage

/* radix4_divider.f */
div_arith_pkg.sv
div_ctl_pkg.sv
radix4_stage.sv
radix4_step.sv
div_control.sv
radix4_divider.sv
tb_clock.sv
tb_radix4_divider.sv

/* radix4_divider.sv */
// Multi-cycle radix-4 unsigned divider with trigger, ready and done handshake
module radix4_divider
    import div_arith_pkg::*;
(
    input  logic  ctl_clk,
    input  logic  reset,
    input  word_t a,
    input  word_t b,
    input  logic  trigger,
    output word_t q,
    output word_t r,
    output logic  ready,
    output logic  done
);

    logic load;
    logic shift;
    logic finish;

    // Captured divisor and working word
    word_t divisor_reg;
    work_t work_reg;
    work_t step_result;

    div_control i_div_control (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .trigger (trigger),
        .ready   (ready),
        .done    (done),
        .load    (load),
        .shift   (shift),
        .finish  (finish)
    );

    radix4_step i_radix4_step (
        .work_in  (work_reg),
        .divisor  (divisor_reg),
        .work_out (step_result)
    );

    // Datapath, one iteration per shift cycle
    always_ff @(posedge ctl_clk) begin
        if (load) begin
            divisor_reg <= b;
            work_reg    <= {word_t'(0), a};
        end else if (shift) begin
            work_reg <= step_result;
        end
    end

    // Results hold until the next finish
    always_ff @(posedge ctl_clk) begin
        if (finish) begin
            q <= work_reg[div_width-1:0];
            r <= work_reg[2*div_width-1:div_width];
        end
    end

endmodule

/* radix4_stage.sv */
// Radix-4 digit stage that picks the largest divisor multiple fitting the shifted remainder
module radix4_stage
    import div_arith_pkg::*;
(
    input  word_t                rem_in,
    input  logic [1:0]           dividend_bits,
    input  word_t                divisor_x1,
    input  logic [div_width+1:0] divisor_x2,
    input  logic [div_width+1:0] divisor_x3,
    output word_t                rem_out,
    output digit_t               digit
);

    // Two extra bits, the shifted remainder can reach four times the divisor
    logic [div_width+1:0] shifted;

    // Trial differences with one borrow bit on top
    logic [div_width+2:0] diff_x1;
    logic [div_width+2:0] diff_x2;
    logic [div_width+2:0] diff_x3;

    logic fits_x1;
    logic fits_x2;
    logic fits_x3;

    assign shifted = {rem_in, dividend_bits};

    assign diff_x1 = {1'b0, shifted} - {3'b000, divisor_x1};
    assign diff_x2 = {1'b0, shifted} - {1'b0, divisor_x2};
    assign diff_x3 = {1'b0, shifted} - {1'b0, divisor_x3};

    // No borrow means the multiple fits
    assign fits_x1 = ~diff_x1[div_width+2];
    assign fits_x2 = ~diff_x2[div_width+2];
    assign fits_x3 = ~diff_x3[div_width+2];

    // Priority selector, largest multiple first
    always_comb begin
        if (fits_x3) begin
            rem_out = diff_x3[div_width-1:0];
            digit   = 2'd3;
        end else if (fits_x2) begin
            rem_out = diff_x2[div_width-1:0];
            digit   = 2'd2;
        end else if (fits_x1) begin
            rem_out = diff_x1[div_width-1:0];
            digit   = 2'd1;
        end else begin
            rem_out = shifted[div_width-1:0];
            digit   = 2'd0;
        end
    end

endmodule

/* radix4_step.sv */
// Radix-4 iteration step that chains the digit stages over eight dividend bits
module radix4_step
    import div_arith_pkg::*;
(
    input  work_t work_in,
    input  word_t divisor,
    output work_t work_out
);

    // Multiples keep their carry so large divisors still compare right
    logic [div_width+1:0] divisor_x2;
    logic [div_width+1:0] divisor_x3;

    // Partial remainder between stages
    word_t rem_chain [digits_per_step+1];

    digit_t digits [digits_per_step];

    assign divisor_x2 = {1'b0, divisor, 1'b0};
    assign divisor_x3 = divisor_x2 + {2'b00, divisor};

    assign rem_chain[0] = work_in[2*div_width-1:div_width];

    for (genvar i = 0; i < digits_per_step; i++) begin : g_stage
        radix4_stage i_radix4_stage (
            .rem_in        (rem_chain[i]),
            .dividend_bits (work_in[div_width-1-2*i -: 2]),
            .divisor_x1    (divisor),
            .divisor_x2    (divisor_x2),
            .divisor_x3    (divisor_x3),
            .rem_out       (rem_chain[i+1]),
            .digit         (digits[i])
        );

        // First stage gives the most significant digit
        assign work_out[2*(digits_per_step-1-i) +: 2] = digits[i];
    end

    assign work_out[2*div_width-1:div_width] = rem_chain[digits_per_step];

    // Unused dividend bits move up past the consumed ones
    assign work_out[div_width-1:2*digits_per_step] =
        work_in[div_width-1-2*digits_per_step:0];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f radix4_divider.f \
    --top-module tb_radix4_divider \
    -o sim_radix4_divider

# The log decides the result, so a nonzero exit must not stop the script here
./obj_dir/sim_radix4_divider > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation finished cleanly"

/* tb_clock.sv */
// Testbench clock and reset generator for the divider
module tb_clock (
    output logic ctl_clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 16;

    initial begin
        ctl_clk = 1'b0;
        forever #2 ctl_clk = ~ctl_clk;
    end

    // Active low, released just after a rising edge
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge ctl_clk);
        #1 reset = 1'b1;
    end

endmodule

/* tb_radix4_divider.sv */
// Testbench for the radix-4 divider with directed, random and handshake checks
module tb_radix4_divider;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 40;
    localparam int done_latency   = 5;
    localparam int table_rows     = 16;
    localparam int random_count   = 200;

    logic        ctl_clk;
    logic        reset;
    logic [31:0] a;
    logic [31:0] b;
    logic        trigger;
    logic [31:0] q;
    logic [31:0] r;
    logic        ready;
    logic        done;

    // Directed rows of dividend, divisor, quotient and remainder
    logic [31:0] tab_a [table_rows] = '{
        32'h0000_0005, 32'h1234_5678, 32'hdead_beef, 32'hffff_ffff,
        32'hffff_ffff, 32'h7fff_ffff, 32'hffff_fffe, 32'h0000_0064,
        32'h0000_0000, 32'h000f_4240, 32'hffff_ffff, 32'h8000_0000,
        32'h1234_5678, 32'h0000_0000, 32'hffff_ffff, 32'hffff_ffff
    };
    logic [31:0] tab_b [table_rows] = '{
        32'h0000_0007, 32'h0000_0001, 32'hdead_beef, 32'h0000_0003,
        32'h8000_0000, 32'h8000_0001, 32'hc000_0000, 32'h0000_0007,
        32'h0000_0005, 32'h0000_03e8, 32'h0000_0010, 32'hffff_ffff,
        32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_000a
    };
    logic [31:0] tab_q [table_rows] = '{
        32'h0000_0000, 32'h1234_5678, 32'h0000_0001, 32'h5555_5555,
        32'h0000_0001, 32'h0000_0000, 32'h0000_0001, 32'h0000_000e,
        32'h0000_0000, 32'h0000_03e8, 32'h0fff_ffff, 32'h0000_0000,
        32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'h1999_9999
    };
    logic [31:0] tab_r [table_rows] = '{
        32'h0000_0005, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
        32'h7fff_ffff, 32'h7fff_ffff, 32'h3fff_fffe, 32'h0000_0002,
        32'h0000_0000, 32'h0000_0000, 32'h0000_000f, 32'h8000_0000,
        32'h1234_5678, 32'h0000_0000, 32'hffff_ffff, 32'h0000_0005
    };

    tb_clock i_tb_clock (
        .ctl_clk (ctl_clk),
        .reset   (reset)
    );

    radix4_divider i_radix4_divider (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .trigger (trigger),
        .q       (q),
        .r       (r),
        .ready   (ready),
        .done    (done)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s after %0d cycles", what, timeout_cycles);
        $display("*** FAILED ***");
        $fatal(1, "Stopping after a timeout");
    endtask

    // Outputs are settled and inputs change 1 ns after the edge
    task automatic next_edge();
        @(posedge ctl_clk);
        #1;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (ready !== 1'b1) begin
            if (cycles == timeout_cycles) begin
                report_timeout("ready");
            end
            next_edge();
            cycles++;
        end
    endtask

    // Returns the number of edges up to and including the done edge
    task automatic wait_done(output int edges);
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen) begin
            if (edges == timeout_cycles) begin
                report_timeout("done");
            end
            next_edge();
            edges++;
            seen = (done === 1'b1);
        end
    endtask

    // Leaves the caller just after the accepting edge
    task automatic start_division(input logic [31:0] op_a, input logic [31:0] op_b);
        wait_ready();
        a       = op_a;
        b       = op_b;
        trigger = 1'b1;
        next_edge();
        trigger = 1'b0;
        check_value("ready", 32'(ready), 32'h0);
    endtask

    task automatic run_division(input logic [31:0] op_a, input logic [31:0] op_b,
                                input logic [31:0] exp_q, input logic [31:0] exp_r);
        int edges;
        start_division(op_a, op_b);
        wait_done(edges);
        check_value("done latency", 32'(edges), 32'(done_latency));
        check_value("q", q, exp_q);
        check_value("r", r, exp_r);
        // Pulse lasts one cycle and results hold
        next_edge();
        check_value("done", 32'(done), 32'h0);
        check_value("q", q, exp_q);
        check_value("r", r, exp_r);
    endtask

    function automatic logic [31:0] ref_quotient(input logic [31:0] x, input logic [31:0] y);
        if (y == 32'h0) begin
            return 32'hffff_ffff;
        end
        return x / y;
    endfunction

    function automatic logic [31:0] ref_remainder(input logic [31:0] x, input logic [31:0] y);
        if (y == 32'h0) begin
            return x;
        end
        return x % y;
    endfunction

    // Second trigger lands on the done edge of the first division
    task automatic check_back_to_back();
        int edges;
        int more_edges;
        start_division(32'h9abc_def0, 32'h0000_1234);
        edges = 0;
        while (ready !== 1'b1) begin
            if (edges == timeout_cycles) begin
                report_timeout("ready before the done edge");
            end
            next_edge();
            edges++;
        end
        a       = 32'h0fed_cba9;
        b       = 32'h0000_0077;
        trigger = 1'b1;
        next_edge();
        edges++;
        trigger = 1'b0;
        check_value("done latency", 32'(edges), 32'(done_latency));
        check_value("done", 32'(done), 32'h1);
        check_value("ready", 32'(ready), 32'h0);
        check_value("q", q, ref_quotient(32'h9abc_def0, 32'h0000_1234));
        check_value("r", r, ref_remainder(32'h9abc_def0, 32'h0000_1234));
        wait_done(more_edges);
        check_value("done latency", 32'(more_edges), 32'(done_latency));
        check_value("q", q, ref_quotient(32'h0fed_cba9, 32'h0000_0077));
        check_value("r", r, ref_remainder(32'h0fed_cba9, 32'h0000_0077));
    endtask

    task automatic check_ignored_trigger();
        int edges;
        start_division(32'hcafe_f00d, 32'h0000_0101);
        // Other operands offered while busy
        for (int k = 0; k < 3; k++) begin
            check_value("ready", 32'(ready), 32'h0);
            a       = 32'h0000_0010;
            b       = 32'h0000_0003;
            trigger = 1'b1;
            next_edge();
        end
        trigger = 1'b0;
        wait_done(edges);
        check_value("done latency", 32'(edges), 32'(done_latency - 3));
        check_value("q", q, ref_quotient(32'hcafe_f00d, 32'h0000_0101));
        check_value("r", r, ref_remainder(32'hcafe_f00d, 32'h0000_0101));
        // No second division may follow
        for (int k = 0; k < 8; k++) begin
            next_edge();
            check_value("done", 32'(done), 32'h0);
            check_value("ready", 32'(ready), 32'h1);
        end
    endtask

    initial begin
        int          cycles;
        logic [31:0] op_a;
        logic [31:0] op_b;

        a       = 32'h0;
        b       = 32'h0;
        trigger = 1'b0;
        void'($urandom(32'h96da_554f));

        cycles = 0;
        while (reset !== 1'b1) begin
            if (cycles == timeout_cycles) begin
                report_timeout("reset release");
            end
            next_edge();
            cycles++;
        end
        wait_ready();
        check_value("done", 32'(done), 32'h0);

        for (int i = 0; i < table_rows; i++) begin
            run_division(tab_a[i], tab_b[i], tab_q[i], tab_r[i]);
        end

        for (int i = 0; i < random_count; i++) begin
            op_a = $urandom();
            op_b = $urandom();
            // Small divisors give long quotients
            case (i % 4)
                0: op_b = op_b & 32'h0000_00ff;
                1: op_b = op_b & 32'h0000_000f;
                default: op_b = op_b;
            endcase
            run_division(op_a, op_b, ref_quotient(op_a, op_b), ref_remainder(op_a, op_b));
        end

        check_back_to_back();
        check_ignored_trigger();

        $display("*** PASSED ***");
        $finish;
    end

endmodule
